//--- Bender.yml
package:
  name: hqm_cfg_master_core

sources:
  - hqm_cfg_pkg.sv
  - hqm_apb_cfg_bridge.sv
  - hqm_cfg_ring_node.sv
  - hqm_cfg_rsp_collect.sv
  - hqm_cfg_master_core.sv
  - target: simulation
    files:
      - tb_hqm_cfg_master_core.sv

//--- hqm_apb_cfg_bridge.sv
// APB configuration bridge
`timescale 1ns/100ps

module hqm_apb_cfg_bridge #(
    parameter int NUM_UNITS = 4
) (
      input  logic                                  prim_gated_clk
    , input  logic                                  rst_n

    // APB request side
    , input  logic                                  psel
    , input  logic                                  penable
    , input  logic                                  pwrite
    , input  logic [hqm_cfg_pkg::CFG_ADDR_W-1:0]    paddr
    , input  logic [hqm_cfg_pkg::CFG_DATA_W-1:0]    pwdata

    // From collector
    , input  logic                                  rsp_done

    // Ring head
    , output hqm_cfg_pkg::cfg_ring_t                ring_head
    , output logic                                  cfg_busy
);
    import hqm_cfg_pkg::*;

    br_state_e              state_q;
    br_state_e              state_nxt;
    cfg_ring_t              slot_nxt;
    logic                   setup_phase;
    logic [UNIT_ID_W-1:0]   unit_sel;
    logic [REG_IDX_W-1:0]   idx_sel;

    // --------------------
    // Address decode
    // --------------------
    assign setup_phase  = psel & ~penable;                  // First cycle of a transfer
    assign unit_sel     = paddr[UNIT_ID_LSB +: UNIT_ID_W];
    assign idx_sel      = paddr[REG_IDX_LSB +: REG_IDX_W];

    // --------------------
    // Request FSM
    // --------------------
    always_comb begin
        state_nxt = state_q;
        slot_nxt  = '0;                                     // NOP unless issuing
        unique case (state_q)
            BR_IDLE: begin
                if (setup_phase) begin
                    state_nxt     = BR_BUSY;
                    slot_nxt.op   = pwrite ? CFG_WRITE : CFG_READ;
                    slot_nxt.unit = unit_sel;
                    slot_nxt.idx  = idx_sel;
                    slot_nxt.data = pwrite ? pwdata : '0;
                end
            end
            BR_BUSY: begin
                if (rsp_done) begin
                    state_nxt = BR_IDLE;                    // Ring free again
                end
            end
            default: begin
                state_nxt = BR_IDLE;
            end
        endcase
    end

    always_ff @(posedge prim_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= BR_IDLE;
            ring_head <= '0;
        end else begin
            state_q   <= state_nxt;
            ring_head <= slot_nxt;                          // Single-cycle strobe
        end
    end

    // A new setup phase is ignored while busy
    assign cfg_busy = (state_q == BR_BUSY);

endmodule

//--- hqm_cfg_master_core.sv
// Configuration master core
`timescale 1ns/100ps

module hqm_cfg_master_core #(
    parameter int NUM_UNITS = 4
) (
      input  logic                                          prim_gated_clk
    , input  logic                                          rst_n

    // APB slave
    , input  logic                                          psel
    , input  logic                                          penable
    , input  logic                                          pwrite
    , input  logic [hqm_cfg_pkg::CFG_ADDR_W-1:0]            paddr
    , input  logic [hqm_cfg_pkg::CFG_DATA_W-1:0]            pwdata
    , output logic                                          pready
    , output logic                                          pslverr
    , output logic [hqm_cfg_pkg::CFG_DATA_W-1:0]            prdata
    , output logic                                          prdata_par

    // Unit status
    , input  hqm_cfg_pkg::unit_status_t [NUM_UNITS-1:0]     unit_status
    , output logic                                          proc_reset_done
    , output logic                                          proc_idle
);
    import hqm_cfg_pkg::*;

    cfg_ring_t [NUM_UNITS:0]    ring_seg;                   // Entry 0 is head, last is tail
    logic                       rsp_done;
    logic                       cfg_busy;

    hqm_apb_cfg_bridge #(
        .NUM_UNITS ( NUM_UNITS )
    ) hqm_apb_cfg_bridge_inst (
          .prim_gated_clk   ( prim_gated_clk )
        , .rst_n            ( rst_n )
        , .psel             ( psel )
        , .penable          ( penable )
        , .pwrite           ( pwrite )
        , .paddr            ( paddr )
        , .pwdata           ( pwdata )
        , .rsp_done         ( rsp_done )
        , .ring_head        ( ring_seg[0] )
        , .cfg_busy         ( cfg_busy )
    );

    // --------------------
    // Register nodes
    // --------------------
    for (genvar k = 0; k < NUM_UNITS; k++) begin : g_node
        hqm_cfg_ring_node #(
            .UNIT_IDX ( k )
        ) hqm_cfg_ring_node_inst (
              .prim_gated_clk   ( prim_gated_clk )
            , .rst_n            ( rst_n )
            , .ring_in          ( ring_seg[k] )
            , .status           ( unit_status[k] )
            , .ring_out         ( ring_seg[k+1] )
        );
    end

    hqm_cfg_rsp_collect #(
        .NUM_UNITS ( NUM_UNITS )
    ) hqm_cfg_rsp_collect_inst (
          .prim_gated_clk   ( prim_gated_clk )
        , .rst_n            ( rst_n )
        , .ring_tail        ( ring_seg[NUM_UNITS] )
        , .unit_status      ( unit_status )
        , .cfg_busy         ( cfg_busy )
        , .pready           ( pready )
        , .pslverr          ( pslverr )
        , .prdata_par       ( prdata_par )
        , .prdata           ( prdata )
        , .rsp_done         ( rsp_done )
        , .proc_reset_done  ( proc_reset_done )
        , .proc_idle        ( proc_idle )
    );

endmodule

//--- hqm_cfg_pkg.sv
// Configuration ring definitions
package hqm_cfg_pkg;

    // --------------------
    // APB widths
    // --------------------
    localparam int CFG_ADDR_W = 32;
    localparam int CFG_DATA_W = 32;

    // --------------------
    // Address decode fields
    // --------------------
    localparam int UNIT_ID_LSB = 28;                 // Unit select in paddr[31:28]
    localparam int UNIT_ID_W   = 4;                  // Up to 16 units
    localparam int REG_IDX_LSB = 2;                  // Word index in paddr[3:2]
    localparam int REG_IDX_W   = 2;

    localparam logic [REG_IDX_W-1:0] STATUS_REG_IDX = 2'd3;  // Read-only status register

    // Ring opcode
    typedef enum logic [1:0] {
        CFG_NOP   = 2'd0,
        CFG_READ  = 2'd1,
        CFG_WRITE = 2'd2
    } cfg_op_e;

    // APB bridge FSM
    typedef enum logic {
        BR_IDLE = 1'b0,
        BR_BUSY = 1'b1
    } br_state_e;

    // One slot on the configuration ring
    typedef struct packed {
        cfg_op_e                op;
        logic [UNIT_ID_W-1:0]   unit;
        logic [REG_IDX_W-1:0]   idx;
        logic [CFG_DATA_W-1:0]  data;                // Write data down, read data once claimed
        logic                   ack;                 // Set by claiming node
        logic                   err;                 // Illegal access
    } cfg_ring_t;

    // Per-unit status from the processing units
    typedef struct packed {
        logic reset_done;
        logic idle;
    } unit_status_t;

endpackage

//--- hqm_cfg_ring_node.sv
// Unit register node on the configuration ring
`timescale 1ns/100ps

module hqm_cfg_ring_node #(
    parameter int UNIT_IDX = 0
) (
      input  logic                                  prim_gated_clk
    , input  logic                                  rst_n

    , input  hqm_cfg_pkg::cfg_ring_t                ring_in
    , input  hqm_cfg_pkg::unit_status_t             status
    , output hqm_cfg_pkg::cfg_ring_t                ring_out
);
    import hqm_cfg_pkg::*;

    localparam int NUM_CTL_REGS = int'(STATUS_REG_IDX);    // Indices below status are R/W

    logic [CFG_DATA_W-1:0]  ctl_q [NUM_CTL_REGS];
    cfg_ring_t              slot_nxt;
    logic                   claim;
    logic                   is_status;
    logic                   ctl_wr;

    // --------------------
    // Slot decode
    // --------------------
    assign claim     = (ring_in.op != CFG_NOP) &&
                       (ring_in.unit == UNIT_ID_W'(UNIT_IDX)) &&
                       !ring_in.ack;                        // First matching node only
    assign is_status = (ring_in.idx == STATUS_REG_IDX);
    assign ctl_wr    = claim && (ring_in.op == CFG_WRITE) && !is_status;

    always_comb begin
        slot_nxt = ring_in;                                 // Pass through by default
        if (claim) begin
            slot_nxt.ack = 1'b1;
            if (ring_in.op == CFG_READ) begin
                if (is_status) begin
                    slot_nxt.data = '0;
                    slot_nxt.data[1] = status.reset_done;
                    slot_nxt.data[0] = status.idle;
                end else begin
                    slot_nxt.data = ctl_q[ring_in.idx];
                end
            end else if (is_status) begin
                // Status is read-only, reject the write
                slot_nxt.err  = 1'b1;
                slot_nxt.data = '0;
            end
        end
    end

    // --------------------
    // Control registers
    // --------------------
    always_ff @(posedge prim_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CTL_REGS; i++) begin
                ctl_q[i] <= '0;
            end
        end else if (ctl_wr) begin
            ctl_q[ring_in.idx] <= ring_in.data;
        end
    end

    // One cycle per hop
    always_ff @(posedge prim_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            ring_out <= '0;                                 // CFG_NOP
        end else begin
            ring_out <= slot_nxt;
        end
    end

endmodule

//--- hqm_cfg_rsp_collect.sv
// Ring response collector
`timescale 1ns/100ps

module hqm_cfg_rsp_collect #(
    parameter int NUM_UNITS = 4
) (
      input  logic                                          prim_gated_clk
    , input  logic                                          rst_n

    , input  hqm_cfg_pkg::cfg_ring_t                        ring_tail
    , input  hqm_cfg_pkg::unit_status_t [NUM_UNITS-1:0]     unit_status
    , input  logic                                          cfg_busy

    // APB response
    , output logic                                          pready
    , output logic                                          pslverr
    , output logic                                          prdata_par
    , output logic [hqm_cfg_pkg::CFG_DATA_W-1:0]            prdata

    , output logic                                          rsp_done
    , output logic                                          proc_reset_done
    , output logic                                          proc_idle
);
    import hqm_cfg_pkg::*;

    logic                   slot_vld;
    logic                   slot_err;
    logic [CFG_DATA_W-1:0]  rdata_nxt;
    logic                   all_done;
    logic                   all_idle;

    // --------------------
    // Response path
    // --------------------
    assign slot_vld  = (ring_tail.op != CFG_NOP);
    assign slot_err  = ring_tail.err | ~ring_tail.ack;      // Unclaimed means no such unit
    assign rdata_nxt = (slot_vld && !slot_err) ? ring_tail.data : '0;

    always_ff @(posedge prim_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            pready     <= 1'b0;
            pslverr    <= 1'b0;
            prdata     <= '0;
            prdata_par <= 1'b0;
        end else begin
            pready     <= slot_vld;                         // One-cycle strobe
            pslverr    <= slot_vld & slot_err;
            prdata     <= rdata_nxt;
            prdata_par <= ^rdata_nxt;
        end
    end

    assign rsp_done = pready;                               // Releases the bridge

    // --------------------
    // Status aggregates
    // --------------------
    always_comb begin
        all_done = 1'b1;
        all_idle = 1'b1;
        for (int k = 0; k < NUM_UNITS; k++) begin
            all_done &= unit_status[k].reset_done;
            all_idle &= unit_status[k].idle;
        end
    end

    always_ff @(posedge prim_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            proc_reset_done <= 1'b0;
            proc_idle       <= 1'b0;
        end else begin
            proc_reset_done <= all_done;
            proc_idle       <= all_idle & ~cfg_busy;        // Not idle with a transfer open
        end
    end

endmodule

//--- sim.f
hqm_cfg_pkg.sv
hqm_apb_cfg_bridge.sv
hqm_cfg_ring_node.sv
hqm_cfg_rsp_collect.sv
hqm_cfg_master_core.sv
tb_hqm_cfg_master_core.sv

//--- tb_hqm_cfg_master_core.sv
// Configuration master core testbench
`timescale 1ns/100ps

module tb_hqm_cfg_master_core;
    import hqm_cfg_pkg::*;

    localparam int NUM_UNITS = 4;
    localparam int NUM_CTL   = 3;                       // Control registers per unit
    localparam int MAX_WAIT  = 20;
    localparam int NUM_XFERS = 200;

    logic                           prim_gated_clk;
    logic                           rst_n;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [CFG_ADDR_W-1:0]          paddr;
    logic [CFG_DATA_W-1:0]          pwdata;
    logic                           pready;
    logic                           pslverr;
    logic [CFG_DATA_W-1:0]          prdata;
    logic                           prdata_par;
    unit_status_t [NUM_UNITS-1:0]   unit_status;
    logic                           proc_reset_done;
    logic                           proc_idle;

    logic [CFG_DATA_W-1:0]  model_regs [NUM_UNITS][NUM_CTL];
    logic [31:0]            rng_state;
    int                     value_errs;
    int                     timeout_errs;

    hqm_cfg_master_core #(
        .NUM_UNITS ( NUM_UNITS )
    ) hqm_cfg_master_core_inst (
        .prim_gated_clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .pready, .pslverr, .prdata, .prdata_par,
        .unit_status, .proc_reset_done, .proc_idle
    );

    initial begin
        prim_gated_clk = 1'b0;
        forever #50 prim_gated_clk = ~prim_gated_clk;   // 100 ns period
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_counts();
        $display("Errors: value=%0d timeout=%0d", value_errs, timeout_errs);
    endtask

    // --------------------
    // APB master
    // --------------------
    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output logic ok);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        rdata  = '0;
        err    = 1'b0;
        @(posedge prim_gated_clk);
        psel    <= 1'b1;                                // Setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge prim_gated_clk);
        penable <= 1'b1;                                // Access phase held until pready
        while (!seen && waited < MAX_WAIT) begin
            @(negedge prim_gated_clk);
            if (pready) begin
                seen = 1'b1;
            end else begin
                waited++;
            end
        end
        assert (seen) else begin
            timeout_errs++;
            $display("pready did not arrive within %0d cycles, addr %h", MAX_WAIT, addr);
        end
        ok = seen;
        if (seen) begin
            rdata = prdata;
            err   = pslverr;
            check_value("prdata_par", 32'(prdata_par), 32'(^prdata));
            check_value("proc_idle", 32'(proc_idle), 32'h0);   // Transfer still open
        end
        @(posedge prim_gated_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Expected response from the register map, then one APB transfer
    task automatic run_xfer(input logic wr, input int unit, input int idx);
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] exp_data;
        logic        err;
        logic        exp_err;
        logic        ok;
        addr        = lcg_next();                       // Undecoded bits stay random
        addr[31:28] = unit[3:0];
        addr[3:2]   = idx[1:0];
        wdata       = lcg_next();
        exp_err     = 1'b0;
        exp_data    = '0;
        if (unit >= NUM_UNITS) begin
            exp_err = 1'b1;                             // No node on the ring
        end else if (idx == 3) begin
            if (wr) begin
                exp_err = 1'b1;                         // Status is read-only
            end else begin
                exp_data = {30'b0, unit_status[unit].reset_done, unit_status[unit].idle};
            end
        end else if (wr) begin
            model_regs[unit][idx] = wdata;
        end else begin
            exp_data = model_regs[unit][idx];
        end
        apb_access(wr, addr, wdata, rdata, err, ok);
        if (ok) begin
            check_value("pslverr", 32'(err), 32'(exp_err));
            if (!wr || exp_err) begin
                check_value("prdata", rdata, exp_data);
            end
        end
    endtask

    task automatic check_aggregates();
        logic [31:0]                  r;
        unit_status_t [NUM_UNITS-1:0] new_status;
        logic                         exp_done;
        logic                         exp_idle;
        r          = lcg_next();
        new_status = r[23:16] | r[31:24];               // Bias bits towards one
        exp_done   = 1'b1;
        exp_idle   = 1'b1;
        for (int k = 0; k < NUM_UNITS; k++) begin
            exp_done &= new_status[k].reset_done;
            exp_idle &= new_status[k].idle;
        end
        @(posedge prim_gated_clk);
        unit_status <= new_status;
        repeat (2) @(posedge prim_gated_clk);           // Two idle cycles
        @(negedge prim_gated_clk);
        check_value("proc_reset_done", 32'(proc_reset_done), 32'(exp_done));
        check_value("proc_idle", 32'(proc_idle), 32'(exp_idle));
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0] r;
        rng_state    = 32'hfc3a;
        value_errs   = 0;
        timeout_errs = 0;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        unit_status  = '0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            for (int i = 0; i < NUM_CTL; i++) begin
                model_regs[u][i] = '0;
            end
        end
        repeat (5) @(posedge prim_gated_clk);
        rst_n <= 1'b1;
        @(negedge prim_gated_clk);
        check_value("pready", 32'(pready), 32'h0);
        check_value("pslverr", 32'(pslverr), 32'h0);
        check_value("proc_reset_done", 32'(proc_reset_done), 32'h0);
        check_value("proc_idle", 32'(proc_idle), 32'h0);
        for (int u = 0; u < NUM_UNITS; u++) begin
            for (int i = 0; i < NUM_CTL; i++) begin
                run_xfer(1'b0, u, i);                   // Reset value of each register
            end
        end
        check_aggregates();
        for (int u = 0; u < NUM_UNITS; u++) begin
            run_xfer(1'b0, u, 3);
            run_xfer(1'b1, u, 3);
            run_xfer(1'b0, u, 3);                       // Status survives the rejected write
        end
        for (int n = 0; n < NUM_XFERS; n++) begin
            r = lcg_next();
            if (r[31:28] < 2) begin
                run_xfer(r[16], 4 + int'(r[27:24]) % 12, int'(r[9:8]));
            end else if (r[31:28] < 4) begin
                run_xfer(r[16], int'(r[21:20]), 3);
            end else begin
                run_xfer(r[16], int'(r[21:20]), int'(r[25:24]) % NUM_CTL);
            end
            if (n % 10 == 9) begin
                check_aggregates();
            end
        end
        report_counts();
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
